/* logic/histIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface histIf;
    import sifhPkg::*;

    logic  clear;      // level, zero all bins
    logic  hit;        // one photon for binIdx
    binT   binIdx;
    logic  scan;       // pulse, start peak search
    logic  busy;       // hit in flight or clear running
    binT   peakBin;
    countT peakCount;
    logic  scanDone;   // pulse, peak outputs valid

    modport ctrl (
        output clear, hit, binIdx, scan,
        input  busy, scanDone, peakBin
    );

    modport unit (
        input  clear, hit, binIdx, scan,
        output busy, scanDone, peakBin, peakCount
    );

    modport combine (
        input peakBin, peakCount
    );

endinterface

`default_nettype wire

/* logic/histUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module histUnit (
    input logic clk,
    input logic res,
    histIf.unit bus
);
    import sifhPkg::*;

    countT mem [BIN_NUM];

    binT   clrAddr;
    logic  s1Valid;     // hit read done, write next edge
    binT   s1Bin;
    countT s1Count;
    countT incCount;
    countT fwdCount;

    logic  scanning;
    binT   scanAddr;
    logic  rdValid;
    binT   rdBin;
    countT rdCount;
    binT   maxBin;
    countT maxCount;
    logic  scanDone;

    // saturating increment of the stage-1 value
    assign incCount = (s1Count == '1) ? s1Count : s1Count + 1'b1;

    // same bin as the write landing this edge, take the new value
    assign fwdCount = (s1Valid && (s1Bin == bus.binIdx)) ? incCount : mem[bus.binIdx];

    assign bus.busy      = bus.hit | s1Valid | bus.clear;
    assign bus.peakBin   = maxBin;
    assign bus.peakCount = maxCount;
    assign bus.scanDone  = scanDone;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clrAddr <= '0;
            s1Valid <= 1'b0;
        end else begin
            clrAddr <= bus.clear ? clrAddr + 1'b1 : '0;  // walks 0..63 then wraps
            s1Valid <= bus.hit && !bus.clear;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= bus.binIdx;
        s1Count <= fwdCount;
        rdBin   <= scanAddr;
        rdCount <= mem[scanAddr];
    end

    always_ff @(posedge clk) begin
        if (bus.clear) begin
            mem[clrAddr] <= '0;
        end else if (s1Valid) begin
            mem[s1Bin] <= incCount;  // second stage, write back
        end
    end

    // scan: one address per cycle, read register, then compare
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning <= 1'b0;
            scanAddr <= '0;
            rdValid  <= 1'b0;
            maxBin   <= '0;
            maxCount <= '0;
            scanDone <= 1'b0;
        end else begin
            scanDone <= 1'b0;
            rdValid  <= scanning;
            if (rdValid) begin
                if (rdCount > maxCount) begin  // strict, lower bin keeps a tie
                    maxCount <= rdCount;
                    maxBin   <= rdBin;
                end
                if (rdBin == binT'(BIN_NUM - 1)) begin
                    scanDone <= 1'b1;
                end
            end
            if (bus.clear) begin
                scanning <= 1'b0;
                scanAddr <= '0;
                maxBin   <= '0;
                maxCount <= '0;
            end else if (bus.scan) begin
                scanning <= 1'b1;
                scanAddr <= '0;
                maxBin   <= '0;
                maxCount <= '0;
            end else if (scanning) begin
                scanAddr <= scanAddr + 1'b1;
                if (scanAddr == binT'(BIN_NUM - 1)) begin
                    scanning <= 1'b0;  // last bin handed to read stage
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/peakCombine.sv */
`timescale 1ns/1ps
`default_nettype none

module peakCombine (
    input  logic           clk,
    input  logic           res,
    input  logic           publish,
    histIf.combine         coarse,
    histIf.combine         fine,
    output sifhPkg::timeT  peakTime,
    output sifhPkg::countT peakCount,
    output logic           noPeak,
    output logic           resultValid
);
    import sifhPkg::*;

    logic fineEmpty;
    binT  lowBits;

    assign fineEmpty = (fine.peakCount == '0);
    assign lowBits   = fineEmpty ? FINE_CENTER : fine.peakBin;  // mid of coarse bin

    always_ff @(posedge clk) begin
        if (publish) begin
            peakTime  <= {coarse.peakBin, lowBits};
            peakCount <= fine.peakCount;
            noPeak    <= fineEmpty;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= publish;  // one pulse per frame
        end
    end

endmodule

`default_nettype wire

/* logic/sifhCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhCtrl (
    input  logic          clk,
    input  logic          res,
    input  logic          start,
    input  sifhPkg::timeT data,
    input  logic          dataValid,
    output logic          tdcEnable,
    output logic          publish,
    histIf.ctrl           coarse,
    histIf.ctrl           fine
);
    import sifhPkg::*;

    ctrlState state;

    logic [PHOTON_W-1:0] photonCnt;
    binT  clrCnt;
    logic accept;
    logic lastPhoton;
    logic inWindow;
    binT  coarseBin;
    binT  fineBin;

    // strobes outside the enable window do not count
    assign accept     = dataValid && tdcEnable;
    assign lastPhoton = accept && (photonCnt == PHOTON_W'(PHOTON_NUM - 1));

    assign coarseBin = data[TIME_W-1 -: BIN_W];  // upper time bits
    assign fineBin   = data[BIN_W-1:0];
    assign inWindow  = (coarseBin == coarse.peakBin);

    always_ff @(posedge clk) begin
        coarse.binIdx <= coarseBin;  // qualified by hit
        fine.binIdx   <= fineBin;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state        <= IDLE;
            photonCnt    <= '0;
            clrCnt       <= '0;
            tdcEnable    <= 1'b0;
            publish      <= 1'b0;
            coarse.clear <= 1'b0;
            coarse.hit   <= 1'b0;
            coarse.scan  <= 1'b0;
            fine.clear   <= 1'b0;
            fine.hit     <= 1'b0;
            fine.scan    <= 1'b0;
        end else begin
            coarse.hit  <= 1'b0;
            coarse.scan <= 1'b0;
            fine.hit    <= 1'b0;
            fine.scan   <= 1'b0;
            publish     <= 1'b0;

            case (state)
                IDLE: begin
                    if (start) begin
                        state        <= CLEAR;
                        clrCnt       <= '0;
                        coarse.clear <= 1'b1;
                        fine.clear   <= 1'b1;
                    end
                end
                CLEAR: begin
                    clrCnt <= clrCnt + 1'b1;
                    if (clrCnt == binT'(BIN_NUM - 1)) begin  // 64 cycles done
                        coarse.clear <= 1'b0;
                        fine.clear   <= 1'b0;
                        tdcEnable    <= 1'b1;
                        photonCnt    <= '0;
                        state        <= PASS1;
                    end
                end
                PASS1: begin
                    if (accept) begin
                        coarse.hit <= 1'b1;
                        photonCnt  <= photonCnt + 1'b1;
                    end
                    if (lastPhoton) begin
                        tdcEnable <= 1'b0;
                        state     <= DRAIN1;
                    end
                end
                DRAIN1: begin
                    if (!coarse.busy) begin
                        coarse.scan <= 1'b1;
                        state       <= SCAN1;
                    end
                end
                SCAN1: begin
                    if (coarse.scanDone) begin
                        tdcEnable <= 1'b1;
                        photonCnt <= '0;
                        state     <= PASS2;
                    end
                end
                PASS2: begin
                    if (accept) begin
                        fine.hit  <= inWindow;  // outside the coarse peak, dropped
                        photonCnt <= photonCnt + 1'b1;
                    end
                    if (lastPhoton) begin
                        tdcEnable <= 1'b0;
                        state     <= DRAIN2;
                    end
                end
                DRAIN2: begin
                    if (!fine.busy) begin
                        fine.scan <= 1'b1;
                        state     <= SCAN2;
                    end
                end
                SCAN2: begin
                    if (fine.scanDone) begin
                        publish <= 1'b1;
                        state   <= PUBLISH;
                    end
                end
                PUBLISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/sifhPkg.sv */
`default_nettype none

package sifhPkg;

    localparam int TIME_W   = 12;  // tdc arrival time
    localparam int BIN_W    = 6;   // half a time word
    localparam int BIN_NUM  = 64;  // 2**BIN_W
    localparam int COUNT_W  = 8;   // saturates at 255
    localparam int PHOTON_W = 9;   // wide enough to hold PHOTON_NUM

    localparam int PHOTON_NUM = 256;  // accepted photons per pass

    typedef logic [TIME_W-1:0]  timeT;
    typedef logic [BIN_W-1:0]   binT;
    typedef logic [COUNT_W-1:0] countT;

    // reported low bits when the fine pass saw nothing in the window
    localparam binT FINE_CENTER = binT'(32);

    typedef enum logic [3:0] {
        IDLE,
        CLEAR,    // both units zeroed together
        PASS1,    // coarse histogram build
        DRAIN1,
        SCAN1,
        PASS2,    // fine histogram build inside the coarse window
        DRAIN2,
        SCAN2,
        PUBLISH
    } ctrlState;

endpackage

`default_nettype wire

/* logic/sifhTop.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTop (
    input  logic           clk,
    input  logic           res,
    input  logic           start,
    input  sifhPkg::timeT  data,
    input  logic           dataValid,
    output logic           tdcEnable,
    output sifhPkg::timeT  peakTime,
    output sifhPkg::countT peakCount,
    output logic           noPeak,
    output logic           resultValid
);

    logic publish;  // frame done, latch result

    histIf coarseBus ();
    histIf fineBus ();

    sifhCtrl ctrl (
        .clk       (clk),
        .res       (res),
        .start     (start),
        .data      (data),
        .dataValid (dataValid),
        .tdcEnable (tdcEnable),
        .publish   (publish),
        .coarse    (coarseBus.ctrl),
        .fine      (fineBus.ctrl)
    );

    // upper six time bits
    histUnit coarseHist (
        .clk (clk),
        .res (res),
        .bus (coarseBus.unit)
    );

    // lower six bits, only photons inside the coarse peak
    histUnit fineHist (
        .clk (clk),
        .res (res),
        .bus (fineBus.unit)
    );

    peakCombine combine (
        .clk         (clk),
        .res         (res),
        .publish     (publish),
        .coarse      (coarseBus.combine),
        .fine        (fineBus.combine),
        .peakTime    (peakTime),
        .peakCount   (peakCount),
        .noPeak      (noPeak),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
(verilator --binary --timing --assert --top-module sifhTb -f vlog.f -o sifhSim \
    && ./obj_dir/sifhSim) > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

/* sim/sifhTb.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTb;
    import sifhPkg::*;

    localparam int FRAMES     = 20;
    localparam int CYC_LIMIT  = FRAMES * 1500;
    localparam int FULL       = (1 << COUNT_W) - 1;  // bin counter ceiling
    localparam int CLUSTER    = 0;
    localparam int EMPTY_WIN  = 1;
    localparam int TIED       = 2;
    localparam int SATURATE   = 3;

    logic  clk;
    logic  res;
    logic  start;
    timeT  data;
    logic  dataValid;
    logic  tdcEnable;
    timeT  peakTime;
    countT peakCount;
    logic  noPeak;
    logic  resultValid;

    int   cycleCnt = 0;
    int   coarseHist [BIN_NUM];
    int   fineHist [BIN_NUM];
    int   accepted;     // photons counted by the model this frame
    int   coarsePeak;
    logic enSeen;       // enable level at the last falling edge

    sifhTop UUT (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .data        (data),
        .dataValid   (dataValid),
        .tdcEnable   (tdcEnable),
        .peakTime    (peakTime),
        .peakCount   (peakCount),
        .noPeak      (noPeak),
        .resultValid (resultValid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abortRun();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= CYC_LIMIT) begin
            $display("ERROR: timeout, no frame result after %0d clock cycles", cycleCnt);
            abortRun();
        end
    end

    task automatic checkTime(input timeT got, input timeT exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is 0x%03h, expected 0x%03h", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkCount(input countT got, input countT exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            abortRun();
        end
    endtask

    task automatic checkFlag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            abortRun();
        end
    endtask

    // largest count wins, earlier bin keeps a tie
    task automatic findPeak(input bit useFine, output int bin, output int cnt);
        int h;
        int b;
        bin = 0;
        cnt = 0;
        for (b = 0; b < BIN_NUM; b++) begin
            h = useFine ? fineHist[b] : coarseHist[b];
            if (h > cnt) begin
                cnt = h;
                bin = b;
            end
        end
    endtask

    task automatic recordPhoton(input timeT t);
        int cBin;
        int fBin;
        int unused;
        cBin = int'(t[TIME_W-1 -: BIN_W]);
        fBin = int'(t[BIN_W-1:0]);
        if (accepted < PHOTON_NUM) begin
            coarseHist[cBin] = (coarseHist[cBin] < FULL) ? coarseHist[cBin] + 1 : FULL;
        end else if (cBin == coarsePeak) begin  // fine pass window
            fineHist[fBin] = (fineHist[fBin] < FULL) ? fineHist[fBin] + 1 : FULL;
        end
        accepted++;
        if (accepted == PHOTON_NUM) begin
            findPeak(1'b0, coarsePeak, unused);
        end
    endtask

    function automatic timeT makeTime(input int kind, input timeT target);
        bit   pass2;
        bit   even;
        binT  tgtBin;
        timeT t;
        pass2  = (accepted >= PHOTON_NUM);
        even   = (accepted % 2 == 0);
        tgtBin = target[TIME_W-1 -: BIN_W];
        case (kind)
            EMPTY_WIN: begin
                if (!pass2) begin
                    t = {tgtBin, binT'($urandom)};
                end else begin
                    t = {binT'(int'(tgtBin) + 1 + int'($urandom % (BIN_NUM - 1))),
                         binT'($urandom)};  // never the coarse peak
                end
            end
            TIED: begin
                if (!pass2) begin
                    t = {even ? binT'(40) : binT'(20), binT'($urandom)};
                end else begin
                    t = {binT'(20), even ? binT'(50) : binT'(10)};
                end
            end
            SATURATE: t = target;
            default: begin
                if (!enSeen || ($urandom % 10) >= 7) begin
                    t = timeT'($urandom);  // background
                end else begin
                    t = timeT'(int'(target) + int'($urandom % 9) - 4);
                end
            end
        endcase
        return t;
    endfunction

    task automatic runFrame(input int kind);
        timeT target;
        timeT expTime;
        logic expEmpty;
        logic done;
        int   fBin;
        int   fCnt;
        int   b;
        for (b = 0; b < BIN_NUM; b++) begin
            coarseHist[b] = 0;
            fineHist[b]   = 0;
        end
        accepted   = 0;
        coarsePeak = 0;
        target     = timeT'($urandom);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        done = 1'b0;
        while (!done) begin
            dataValid <= (($urandom % 10) < 7);
            data      <= makeTime(kind, target);
            @(negedge clk);
            enSeen = tdcEnable;
            if (dataValid && tdcEnable) begin
                recordPhoton(data);
            end
            if (resultValid) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
            end
        end
        if (accepted != 2 * PHOTON_NUM) begin
            $display("ERROR: result came after %0d accepted photons", accepted);
            abortRun();
        end
        findPeak(1'b1, fBin, fCnt);
        expEmpty = (fCnt == 0);
        expTime  = {binT'(coarsePeak), expEmpty ? FINE_CENTER : binT'(fBin)};
        checkTime(peakTime, expTime, "peakTime");
        checkCount(peakCount, countT'(fCnt), "peakCount");
        checkFlag(noPeak, expEmpty, "noPeak");
        if (kind == EMPTY_WIN) begin
            checkFlag(noPeak, 1'b1, "noPeak for an empty window");
        end
    endtask

    initial begin
        void'($urandom(46675));
        res       = 1'b0;
        start     = 1'b0;
        data      = '0;
        dataValid = 1'b0;
        enSeen    = 1'b0;
        repeat (10) begin
            @(negedge clk);
            checkFlag(tdcEnable, 1'b0, "tdcEnable in reset");
            checkFlag(resultValid, 1'b0, "resultValid in reset");
        end
        @(posedge clk);
        res <= 1'b1;
        repeat (3) begin
            @(negedge clk);
            checkFlag(tdcEnable, 1'b0, "tdcEnable after reset");
            checkFlag(resultValid, 1'b0, "resultValid after reset");
        end
        for (int f = 0; f < FRAMES; f++) begin
            runFrame((f >= 1 && f <= 3) ? f : CLUSTER);  // frames 1..3 are the corner cases
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/sifhTop_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module sifhTopProperties (
    input logic clk,
    input logic res,
    input logic start,
    input logic tdcEnable,
    input logic resultValid
);

    logic [7:0] sinceStart;  // cycles since last start, sticks at max

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sinceStart <= '0;
        end else if (start) begin
            sinceStart <= '0;
        end else if (sinceStart != '1) begin
            sinceStart <= sinceStart + 1'b1;
        end
    end

    resetQuiet: assert property (@(posedge clk) !res |-> (!tdcEnable && !resultValid))
        else $error("tdcEnable or resultValid high while in reset");

    singlePulse: assert property (@(posedge clk) disable iff (!res)
        resultValid |=> !resultValid)
        else $error("resultValid high on two cycles in a row");

    // clear takes 64 cycles before the first pass opens
    lateEnable: assert property (@(posedge clk) disable iff (!res)
        $rose(tdcEnable) |-> (sinceStart >= 8'd64))
        else $error("tdcEnable rose within 64 cycles of start");

endmodule

bind sifhTop sifhTopProperties props (.*);

`default_nettype wire

/* vlog.f */
logic/sifhPkg.sv
logic/histIf.sv
logic/histUnit.sv
logic/sifhCtrl.sv
logic/peakCombine.sv
logic/sifhTop.sv
sim/sifhTop_properties.sv
sim/sifhTb.sv
